//--- hw/fetchPkg.sv
// Fetch front-end shared definitions
// Instruction word views, opcode and destination encodings, control bundle
package fetchPkg;

   // Supported opcodes, anything else decodes as illegal
   typedef enum logic [4:0] {
      HALT = 5'b00000,
      NOP  = 5'b00001,
      J    = 5'b00100,
      JR   = 5'b00101,
      JAL  = 5'b00110,
      ADDI = 5'b01000,
      BEQZ = 5'b01100,
      ST   = 5'b10000,
      LD   = 5'b10001,
      LBI  = 5'b11000,
      ALUR = 5'b11011
   } opcodeT;

   // Which field names the write register
   typedef enum logic [1:0] {
      RS  = 2'd0,   // Bits 10:8
      RDR = 2'd1,   // Bits 4:2, R-type rd
      R7  = 2'd2,   // Link register
      RDI = 2'd3    // Bits 7:5, I-type rd
   } destSelT;

   // R-type view
   typedef struct packed {
      opcodeT     opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] funct;
   } rFormT;

   // I-type view
   typedef struct packed {
      opcodeT     opcode;
      logic [2:0] rs;
      logic [2:0] rd;
      logic [4:0] imm;
   } iFormT;

   // J-type view
   typedef struct packed {
      opcodeT      opcode;
      logic [10:0] disp;
   } jFormT;

   // One 16-bit instruction, read through whichever format applies
   typedef union packed {
      rFormT rView;
      iFormT iView;
      jFormT jView;
   } instrWord;

   // Control signals handed to the later stages
   typedef struct packed {
      logic       regWrite;
      logic       memEnable;
      logic       memWr;
      logic       val2Reg;   // Load result to register file
      logic       aluSel;
      logic [2:0] immSel;    // Immediate format
      logic       bFlag;
      logic       jFlag;
      logic       regJmp;
      logic       link;
      logic       lbi;
      logic       halt;
      logic       ctrlErr;   // Illegal opcode
   } ctrlBundle;

   // NOP opcode with all fields zero
   localparam instrWord nopWord = 16'h0800;

endpackage

//--- hw/progCounter.sv
// Program counter
// Clears in reset, takes a redirect target first, holds on stall, else steps by 2
`timescale 1ns/1ps

module progCounter (
   input  logic        clk,
   input  logic        rstN,
   input  logic        stall,
   input  logic        redirect,
   input  logic [15:0] redirectPc,
   output logic [15:0] pc
);

   logic [15:0] pcNext;

   always_comb begin
      if (redirect) begin
         pcNext = redirectPc;      // Later stage overrides a stall
      end else if (stall) begin
         pcNext = pc;
      end else begin
         pcNext = pc + 16'd2;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc <= '0;
      end else begin
         pc <= pcNext;
      end
   end

endmodule

//--- hw/instrRom.sv
// Instruction memory
// Word array read combinationally by PC, loaded through a clocked write port
// while the core is held in reset
`timescale 1ns/1ps

module instrRom #(
   parameter int memWords = 256
) (
   input  logic              clk,
   input  logic [15:0]       pc,
   input  logic              progWe,
   input  logic [15:0]       progAddr,
   input  fetchPkg::instrWord progData,
   output fetchPkg::instrWord rawInstr
);
   import fetchPkg::*;

   localparam int addrW = (memWords > 1) ? $clog2(memWords) : 1;

   instrWord         mem [memWords];
   logic [addrW-1:0] rdIdx;
   logic [addrW-1:0] wrIdx;

   // Byte address to word index, wrapped to the depth
   assign rdIdx = addrW'(pc[15:1] % memWords);
   assign wrIdx = addrW'(progAddr[15:1] % memWords);

   // Empty slots fetch as NOP
   initial begin
      for (int i = 0; i < memWords; i++) begin
         mem[i] = nopWord;
      end
   end

   always @(posedge clk) begin
      if (progWe) begin
         mem[wrIdx] <= progData;
      end
   end

   assign rawInstr = mem[rdIdx];

endmodule

//--- hw/ctrlDecode.sv
// Control decoder
// Turns an opcode into the control bundle, the write register select
// and the flags saying which source registers are read
`timescale 1ns/1ps

module ctrlDecode (
   input  fetchPkg::instrWord instr,
   output fetchPkg::ctrlBundle ctrl,
   output fetchPkg::destSelT   destSel,
   output logic                usesRs,
   output logic                usesRt,
   output logic                legal
);
   import fetchPkg::*;

   always_comb begin
      ctrl    = '0;
      destSel = RDR;         // Don't care unless regWrite
      usesRs  = 1'b0;
      usesRt  = 1'b0;
      legal   = 1'b1;

      case (instr.rView.opcode)
         HALT: begin
            ctrl.halt = 1'b1;
         end
         NOP: begin
            // No control activity
         end
         J: begin
            ctrl.jFlag  = 1'b1;
            ctrl.immSel = 3'd4;    // 11-bit displacement
         end
         JR: begin
            ctrl.regJmp = 1'b1;
            ctrl.immSel = 3'd5;
            usesRs      = 1'b1;
         end
         JAL: begin
            ctrl.jFlag    = 1'b1;
            ctrl.link     = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.immSel   = 3'd4;
            destSel       = R7;    // Return address
         end
         ADDI: begin
            ctrl.regWrite = 1'b1;
            ctrl.immSel   = 3'd1;
            destSel       = RDI;
            usesRs        = 1'b1;
         end
         BEQZ: begin
            ctrl.bFlag  = 1'b1;
            ctrl.immSel = 3'd3;
            usesRs      = 1'b1;
         end
         ST: begin
            ctrl.memEnable = 1'b1;
            ctrl.memWr     = 1'b1;
            ctrl.immSel    = 3'd1;
            usesRs         = 1'b1;  // Base
            usesRt         = 1'b1;  // Store data
         end
         LD: begin
            ctrl.memEnable = 1'b1;
            ctrl.val2Reg   = 1'b1;
            ctrl.regWrite  = 1'b1;
            ctrl.immSel    = 3'd1;
            destSel        = RDI;
            usesRs         = 1'b1;
         end
         LBI: begin
            ctrl.lbi      = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.immSel   = 3'd2;
            destSel       = RS;     // Writes the rs field
         end
         ALUR: begin
            ctrl.aluSel   = 1'b1;
            ctrl.regWrite = 1'b1;
            destSel       = RDR;
            usesRs        = 1'b1;
            usesRt        = 1'b1;
         end
         default: begin
            ctrl.ctrlErr = 1'b1;    // Only this bit on an unknown code
            legal        = 1'b0;
         end
      endcase
   end

endmodule

//--- hw/hazardUnit.sv
// Read-after-write hazard detector
// Remembers the destinations of the last few issued words and raises a
// bubble when the fetched word reads one of them
`timescale 1ns/1ps

module hazardUnit #(
   parameter int trackDepth = 3
) (
   input  logic               clk,
   input  logic               rstN,
   input  fetchPkg::instrWord fetched,
   input  logic               usesRs,
   input  logic               usesRt,
   input  logic [2:0]         issueDest,
   input  logic               issueWrites,
   output logic               bubble
);
   import fetchPkg::*;

   typedef struct packed {
      logic [2:0] dest;
      logic       writes;
   } scoreEntry;

   scoreEntry sb [trackDepth];   // Entry 0 is the newest
   scoreEntry newEntry;
   logic      rsHit;
   logic      rtHit;

   assign newEntry.dest   = issueDest;
   assign newEntry.writes = issueWrites;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < trackDepth; i++) begin
            sb[i] <= '0;
         end
      end else begin
         sb[0] <= newEntry;
         for (int i = 1; i < trackDepth; i++) begin
            sb[i] <= sb[i-1];
         end
      end
   end

   // Compare both source fields against every live entry
   always_comb begin
      rsHit = 1'b0;
      rtHit = 1'b0;
      for (int i = 0; i < trackDepth; i++) begin
         if (sb[i].writes && (sb[i].dest == fetched.rView.rs)) begin
            rsHit = 1'b1;
         end
         if (sb[i].writes && (sb[i].dest == fetched.rView.rt)) begin
            rtHit = 1'b1;
         end
      end
   end

   assign bubble = (usesRs & rsHit) | (usesRt & rtHit);

endmodule

//--- hw/fetchStage.sv
// Fetch and issue front end
// PC, instruction memory, hazard check and decode. Issues a NOP bubble and
// holds the PC on a hazard; outputs are forced idle while in reset
`timescale 1ns/1ps

module fetchStage #(
   parameter int memWords   = 256,
   parameter int trackDepth = 3
) (
   input  logic                clk,
   input  logic                rstN,
   input  logic                redirect,
   input  logic [15:0]         redirectPc,
   input  logic                progWe,
   input  logic [15:0]         progAddr,
   input  fetchPkg::instrWord  progData,
   output logic [15:0]         pc,
   output fetchPkg::instrWord  instrOut,
   output fetchPkg::ctrlBundle ctrl,
   output logic [2:0]          writeRegAddr,
   output logic                stall,
   output logic                valid
);
   import fetchPkg::*;

   instrWord  rawInstr;
   instrWord  issueWord;
   logic      bubble;

   ctrlBundle chkCtrl;
   destSelT   chkSel;
   logic      chkUsesRs;
   logic      chkUsesRt;
   logic [2:0] chkDest;
   logic      chkWrites;

   ctrlBundle issueCtrl;
   destSelT   issueSel;
   logic      issueLegal;
   logic [2:0] issueDest;

   // Register number named by a destination select
   function automatic logic [2:0] destAddr(input instrWord w, input destSelT sel);
      case (sel)
         RS:      return w.iView.rs;
         RDR:     return w.rView.rd;
         R7:      return 3'd7;
         default: return w.iView.rd;
      endcase
   endfunction

   progCounter pcReg (
      .clk       (clk),
      .rstN      (rstN),
      .stall     (bubble),
      .redirect  (redirect),
      .redirectPc(redirectPc),
      .pc        (pc)
   );

   instrRom #(.memWords(memWords)) rom (
      .clk     (clk),
      .pc      (pc),
      .progWe  (progWe),
      .progAddr(progAddr),
      .progData(progData),
      .rawInstr(rawInstr)
   );

   // Check decode looks at the raw fetched word
   ctrlDecode chkDec (
      .instr  (rawInstr),
      .ctrl   (chkCtrl),
      .destSel(chkSel),
      .usesRs (chkUsesRs),
      .usesRt (chkUsesRt),
      .legal  ()
   );

   assign chkDest   = destAddr(rawInstr, chkSel);
   assign chkWrites = chkCtrl.regWrite & ~bubble;   // A bubble writes nothing

   hazardUnit #(.trackDepth(trackDepth)) hazard (
      .clk        (clk),
      .rstN       (rstN),
      .fetched    (rawInstr),
      .usesRs     (chkUsesRs),
      .usesRt     (chkUsesRt),
      .issueDest  (chkDest),
      .issueWrites(chkWrites),
      .bubble     (bubble)
   );

   assign issueWord = bubble ? nopWord : rawInstr;

   // Issue decode drives the outgoing bundle
   ctrlDecode issDec (
      .instr  (issueWord),
      .ctrl   (issueCtrl),
      .destSel(issueSel),
      .usesRs (),
      .usesRt (),
      .legal  (issueLegal)
   );

   assign issueDest = destAddr(issueWord, issueSel);

   // Idle outputs while reset is held
   assign instrOut     = rstN ? issueWord : nopWord;
   assign ctrl         = rstN ? issueCtrl : '0;
   assign writeRegAddr = rstN ? issueDest : 3'd0;
   assign stall        = rstN & bubble;
   assign valid        = rstN & ~bubble & issueLegal &
                         (issueWord.rView.opcode != NOP);

endmodule

//--- testbench/tbFetchStage.sv
// Testbench for the fetch and issue front end
// Loads a random program during reset, then runs it against a behavioural
// model of PC, memory, scoreboard and decode, with random redirect pulses
`timescale 1ns/1ps

module tbFetchStage;
   import fetchPkg::*;

   localparam int memWords    = 16;
   localparam int trackDepth  = 3;
   localparam int addrW       = $clog2(memWords);
   localparam int resetCycles = 10;
   localparam int runCycles   = 400;
   localparam int clkPeriod   = 40;
   localparam int watchdogNs  = (resetCycles + runCycles) * 4 * clkPeriod;

   logic        clk;
   logic        rstN;
   logic        redirect;
   logic [15:0] redirectPc;
   logic        progWe;
   logic [15:0] progAddr;
   instrWord    progData;
   logic [15:0] pc;
   instrWord    instrOut;
   ctrlBundle   ctrl;
   logic [2:0]  writeRegAddr;
   logic        stall;
   logic        valid;

   // Weighted opcode pool, last two entries are illegal codes
   logic [4:0] opTable [16] = '{HALT, NOP, J, JR, JAL, ADDI, BEQZ, ST, LD, LBI, ALUR,
                                ADDI, ALUR, LD, 5'b10111, 5'b00011};

   integer      seed = 69664;
   instrWord    mMem [memWords];     // Model copy of the program
   logic [15:0] mPc;
   logic [2:0]  sbDest [trackDepth]; // Entry 0 is the newest
   logic        sbWr [trackDepth];

   instrWord    eWord;
   ctrlBundle   eCtrl;
   logic [2:0]  eDest;
   logic        eStall;
   logic        eValid;

   int wordErrs = 0;
   int ctrlErrs = 0;
   int regErrs  = 0;
   int flagErrs = 0;
   int pcErrs   = 0;

   fetchStage #(.memWords(memWords), .trackDepth(trackDepth)) i_dut (
      .clk         (clk),
      .rstN        (rstN),
      .redirect    (redirect),
      .redirectPc  (redirectPc),
      .progWe      (progWe),
      .progAddr    (progAddr),
      .progData    (progData),
      .pc          (pc),
      .instrOut    (instrOut),
      .ctrl        (ctrl),
      .writeRegAddr(writeRegAddr),
      .stall       (stall),
      .valid       (valid)
   );

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   // Decode table
   function automatic ctrlBundle decodeCtrl(input instrWord w);
      case (w.rView.opcode)
         HALT:    return '{halt: 1'b1, default: '0};
         NOP:     return '0;
         J:       return '{jFlag: 1'b1, immSel: 3'd4, default: '0};
         JR:      return '{regJmp: 1'b1, immSel: 3'd5, default: '0};
         JAL:     return '{regWrite: 1'b1, jFlag: 1'b1, link: 1'b1, immSel: 3'd4, default: '0};
         ADDI:    return '{regWrite: 1'b1, immSel: 3'd1, default: '0};
         BEQZ:    return '{bFlag: 1'b1, immSel: 3'd3, default: '0};
         ST:      return '{memEnable: 1'b1, memWr: 1'b1, immSel: 3'd1, default: '0};
         LD:      return '{regWrite: 1'b1, memEnable: 1'b1, val2Reg: 1'b1, immSel: 3'd1,
                           default: '0};
         LBI:     return '{regWrite: 1'b1, lbi: 1'b1, immSel: 3'd2, default: '0};
         ALUR:    return '{regWrite: 1'b1, aluSel: 1'b1, default: '0};
         default: return '{ctrlErr: 1'b1, default: '0};
      endcase
   endfunction

   // Write register of a writing opcode
   function automatic logic [2:0] writeDest(input instrWord w);
      case (w.rView.opcode)
         ADDI, LD: return w.iView.rd;
         LBI:      return w.iView.rs;
         ALUR:     return w.rView.rd;
         JAL:      return 3'd7;
         default:  return 3'd0;
      endcase
   endfunction

   task automatic checkWord(input string name, input instrWord got, input instrWord exp);
      if (got !== exp) begin
         wordErrs++;
         $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic checkCtrl(input string name, input ctrlBundle got, input ctrlBundle exp);
      if (got !== exp) begin
         ctrlErrs++;
         $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic checkReg(input string name, input logic [2:0] got, input logic [2:0] exp);
      if (got !== exp) begin
         regErrs++;
         $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         flagErrs++;
         $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic checkPc(input string name, input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         pcErrs++;
         $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic verifyIdle();
      checkWord("instrOut", instrOut, nopWord);
      checkCtrl("ctrl", ctrl, '0);
      checkFlag("valid", valid, 1'b0);
      checkFlag("stall", stall, 1'b0);
      checkPc("pc", pc, 16'h0000);
   endtask

   task automatic makeInstr(output instrWord w);
      logic [31:0] r;
      r = $random(seed);
      w = instrWord'({opTable[r[15:12]], r[10:0]});
   endtask

   // Expected outputs for the current model state
   task automatic predictOutputs();
      instrWord fetched;
      logic     rsUse;
      logic     rtUse;
      logic     hit;
      fetched = mMem[mPc[addrW:1]];
      rsUse   = fetched.rView.opcode inside {ADDI, LD, ST, BEQZ, JR, ALUR};
      rtUse   = fetched.rView.opcode inside {ALUR, ST};
      hit     = 1'b0;
      for (int i = 0; i < trackDepth; i++) begin
         if (sbWr[i] && ((rsUse && sbDest[i] == fetched.rView.rs) ||
                         (rtUse && sbDest[i] == fetched.rView.rt))) begin
            hit = 1'b1;
         end
      end
      eStall = hit;
      eWord  = hit ? nopWord : fetched;   // Bubble on a conflict
      eCtrl  = decodeCtrl(eWord);
      eDest  = writeDest(eWord);
      eValid = !hit && !eCtrl.ctrlErr && (eWord.rView.opcode != NOP);
   endtask

   // All live outputs against the prediction
   task automatic compareOutputs();
      checkPc("pc", pc, mPc);
      checkWord("instrOut", instrOut, eWord);
      checkCtrl("ctrl", ctrl, eCtrl);
      checkFlag("stall", stall, eStall);
      checkFlag("valid", valid, eValid);
      if (eCtrl.regWrite) begin
         checkReg("writeRegAddr", writeRegAddr, eDest);
      end
   endtask

   // Model state across one rising edge
   task automatic stepModel(input logic redir, input logic [15:0] target);
      for (int i = trackDepth - 1; i > 0; i--) begin
         sbDest[i] = sbDest[i-1];
         sbWr[i]   = sbWr[i-1];
      end
      sbDest[0] = eDest;
      sbWr[0]   = eCtrl.regWrite;
      if (redir) begin
         mPc = target;               // Redirect beats a stall
      end else if (!eStall) begin
         mPc = mPc + 16'd2;
      end
   endtask

   initial begin
      #(watchdogNs);
      $display("Timeout: run did not finish within %0d ns", watchdogNs);
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      instrWord    w;
      logic [31:0] r;
      logic        redir;
      logic [15:0] target;
      rstN       = 1'b0;
      redirect   = 1'b0;
      redirectPc = '0;
      progWe     = 1'b0;
      progAddr   = '0;
      progData   = nopWord;
      mPc        = '0;
      for (int i = 0; i < memWords; i++) begin
         mMem[i] = nopWord;
      end
      for (int i = 0; i < trackDepth; i++) begin
         sbDest[i] = '0;
         sbWr[i]   = 1'b0;
      end

      // Program load while reset is held
      for (int i = 0; i < resetCycles; i++) begin
         @(negedge clk);
         verifyIdle();
         makeInstr(w);
         progWe   = 1'b1;
         progAddr = 16'(2 * i);
         progData = w;
         mMem[i]  = w;
      end
      @(negedge clk);
      verifyIdle();
      progWe = 1'b0;
      rstN   = 1'b1;

      // First live half cycle, word at address zero
      #(clkPeriod / 4);
      predictOutputs();
      compareOutputs();
      stepModel(1'b0, 16'h0000);

      for (int c = 0; c < runCycles; c++) begin
         @(negedge clk);
         predictOutputs();
         compareOutputs();
         r      = $random(seed);
         redir  = eStall ? (r[1:0] == 2'd0) : (r[3:0] == 4'd0);   // More often when stalled
         target = {10'd0, r[9:5], 1'b0};
         redirect   = redir;
         redirectPc = target;
         stepModel(redir, target);
      end

      $display("Errors: pc %0d, instrOut %0d, ctrl %0d, writeRegAddr %0d, flags %0d",
               pcErrs, wordErrs, ctrlErrs, regErrs, flagErrs);
      if (pcErrs + wordErrs + ctrlErrs + regErrs + flagErrs == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- files.f
hw/fetchPkg.sv
hw/progCounter.sv
hw/instrRom.sv
hw/ctrlDecode.sv
hw/hazardUnit.sv
hw/fetchStage.sv
testbench/tbFetchStage.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tbFetchStage
FILELIST  = files.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
